//--- jtag_bridge_pkg.sv
`default_nettype none

package jtag_bridge_pkg;

    // Virtual IR codes, same numbering as the debug node instruction set
    typedef enum logic [2:0]
    {
        DATA     = 3'd0,
        LOOPBACK = 3'd1,
        DEBUG    = 3'd2,
        INFO     = 3'd3,
        CONTROL  = 3'd4,
        MGMT     = 3'd5
    } vjtag_instr_e;

    typedef enum logic
    {
        IDLE = 1'b0,
        HOLD = 1'b1 // A DATA byte waits for out_ready
    } sink_state_e;

    typedef struct packed
    {
        vjtag_instr_e mode;    // Instruction active when the byte completed
        logic [7:0]   payload;
    } tagged_byte_t;

    localparam logic [7:0] INFO_ID = 8'hA5; // First byte returned after capture in INFO

endpackage

`default_nettype wire

//--- byte_stream_if.sv
`timescale 1ns/100ps
`default_nettype none

interface byte_stream_if #(
    parameter int FIFO_DEPTH = 8
);
    import jtag_bridge_pkg::*;

    // Entries held include the FIFO output register
    localparam int CNT_W = $clog2(FIFO_DEPTH + 2);

    logic             push_valid;
    tagged_byte_t     push_data;
    logic             full;
    logic [CNT_W-1:0] count;
    logic             pop_valid;
    tagged_byte_t     pop_data;
    logic             pop_ready;

    modport producer (
        output push_valid,
        output push_data,
        input  full,
        input  count
    );

    modport buffer (
        input  push_valid,
        input  push_data,
        output full,
        output count,
        output pop_valid,
        output pop_data,
        input  pop_ready
    );

    modport consumer (
        input  pop_valid,
        input  pop_data,
        output pop_ready
    );

    modport monitor (
        input push_valid,
        input push_data,
        input full,
        input count,
        input pop_valid,
        input pop_data,
        input pop_ready
    );

endinterface

`default_nettype wire

//--- jtag_dr_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_dr_shifter (
    input  wire                           tck,
    input  wire                           arst_n,
    input  jtag_bridge_pkg::vjtag_instr_e ir_in,
    input  wire                           cdr,
    input  wire                           sdr,
    input  wire                           udr,
    input  wire                           tdi,
    output logic                          tdo,
    byte_stream_if.producer               fifo
);
    import jtag_bridge_pkg::*;

    logic [7:0] shift_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] resp_q;
    logic [7:0] last_byte_q;
    logic       info_idx_q;
    logic       ovf_q;

    logic [7:0] new_byte;
    logic       shift_en;
    logic       byte_done;
    logic       load_resp;
    logic [7:0] status_byte;
    logic [7:0] resp_next;

    assign shift_en  = sdr && !cdr;
    assign new_byte  = {tdi, shift_q[7:1]}; // LSB arrives first
    assign byte_done = shift_en && (bit_cnt_q == 3'd7);
    assign load_resp = cdr || byte_done;

    // Sticky overflow on top, fill level below it
    assign status_byte = {ovf_q, 7'(fifo.count)};

    assign tdo = resp_q[0];

    always_comb
    begin
        case (ir_in)
            LOOPBACK:
            begin
                resp_next = cdr ? last_byte_q : new_byte; // Echo lags the input by one byte
            end
            INFO:
            begin
                resp_next = (cdr || !info_idx_q) ? INFO_ID : status_byte;
            end
            default:
            begin
                resp_next = 8'h00;
            end
        endcase
    end

    always_ff @(posedge tck or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt_q       <= '0;
            resp_q          <= '0;
            last_byte_q     <= '0;
            info_idx_q      <= 1'b0;
            ovf_q           <= 1'b0;
            fifo.push_valid <= 1'b0;
        end
        else
        begin
            // INFO scans only read status, their input bits are thrown away
            fifo.push_valid <= byte_done && (ir_in != INFO);

            if (fifo.push_valid && fifo.full)
            begin
                ovf_q <= 1'b1; // The FIFO drops this byte
            end

            if (cdr || udr)
            begin
                bit_cnt_q <= '0; // A partial byte never reaches the FIFO
            end
            else if (sdr)
            begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end

            if (load_resp)
            begin
                resp_q <= resp_next;
            end
            else if (sdr)
            begin
                resp_q <= {1'b0, resp_q[7:1]};
            end

            if (byte_done && (ir_in == LOOPBACK))
            begin
                last_byte_q <= new_byte;
            end

            if (load_resp)
            begin
                info_idx_q <= (ir_in == INFO);
            end
            else if (udr)
            begin
                info_idx_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge tck)
    begin
        if (shift_en)
        begin
            shift_q <= new_byte;
        end
        if (byte_done)
        begin
            fifo.push_data <= {ir_in, new_byte};
        end
    end

endmodule

`default_nettype wire

//--- byte_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire           tck,
    input  wire           arst_n,
    byte_stream_if.buffer buf_if
);
    import jtag_bridge_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 2);

    tagged_byte_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] mem_cnt_q;

    logic             push;
    logic             pop;
    logic             out_free;
    logic             mem_empty;
    logic             load_mem;
    logic             load_push;
    logic             write_mem;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push      = buf_if.push_valid && !buf_if.full;
    assign pop       = buf_if.pop_valid && buf_if.pop_ready;
    assign out_free  = !buf_if.pop_valid || pop;
    assign mem_empty = (mem_cnt_q == '0);

    // The output register refills from memory first so order is kept
    assign load_mem  = out_free && !mem_empty;
    assign load_push = out_free && mem_empty && push;
    assign write_mem = push && !load_push;

    assign buf_if.full  = (mem_cnt_q == CNT_W'(FIFO_DEPTH));
    assign buf_if.count = mem_cnt_q + CNT_W'(buf_if.pop_valid);

    always_ff @(posedge tck or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr_q         <= '0;
            rd_ptr_q         <= '0;
            mem_cnt_q        <= '0;
            buf_if.pop_valid <= 1'b0;
        end
        else
        begin
            if (write_mem)
            begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (load_mem)
            begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            mem_cnt_q <= mem_cnt_q + CNT_W'(write_mem) - CNT_W'(load_mem);
            if (out_free)
            begin
                buf_if.pop_valid <= load_mem || load_push;
            end
        end
    end

    always_ff @(posedge tck)
    begin
        if (write_mem)
        begin
            mem[wr_ptr_q] <= buf_if.push_data;
        end
        if (load_mem)
        begin
            buf_if.pop_data <= mem[rd_ptr_q];
        end
        else if (load_push)
        begin
            buf_if.pop_data <= buf_if.push_data; // Empty FIFO bypasses the memory
        end
    end

endmodule

`default_nettype wire

//--- cmd_sink.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_sink (
    input  wire               tck,
    input  wire               arst_n,
    byte_stream_if.consumer   fifo,
    input  wire               out_ready,
    output logic              out_valid,
    output logic [7:0]        out_data,
    output logic [7:0]        ctrl
);
    import jtag_bridge_pkg::*;

    sink_state_e state_q;
    logic        pop;
    logic        pop_is_data;
    logic        pop_is_ctrl;

    // Holding a DATA byte stalls the FIFO until the stream takes it
    assign fifo.pop_ready = (state_q == IDLE);
    assign pop            = fifo.pop_valid && fifo.pop_ready;
    assign pop_is_data    = pop && (fifo.pop_data.mode == DATA);
    assign pop_is_ctrl    = pop && (fifo.pop_data.mode == CONTROL);
    assign out_valid      = (state_q == HOLD);

    always_ff @(posedge tck or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state_q <= IDLE;
            ctrl    <= 8'h00;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (pop_is_data)
                    begin
                        state_q <= HOLD;
                    end
                end
                HOLD:
                begin
                    if (out_ready)
                    begin
                        state_q <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase

            if (pop_is_ctrl)
            begin
                ctrl <= fifo.pop_data.payload;
            end
        end
    end

    // Loaded only from IDLE, so the byte cannot move while it is offered
    always_ff @(posedge tck)
    begin
        if (pop_is_data)
        begin
            out_data <= fifo.pop_data.payload;
        end
    end

endmodule

`default_nettype wire

//--- jtag_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_bridge_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire       tck,
    input  wire       arst_n,
    input  wire [2:0] ir_in,
    input  wire       virtual_state_cdr,
    input  wire       virtual_state_sdr,
    input  wire       virtual_state_e1dr,
    input  wire       virtual_state_udr,
    input  wire       tdi,
    input  wire       out_ready,
    output wire       tdo,
    output wire       out_valid,
    output wire [7:0] out_data,
    output wire [7:0] ctrl
);
    import jtag_bridge_pkg::*;

    wire dr_end;

    // Both Exit1-DR and Update-DR close the shift phase
    assign dr_end = virtual_state_e1dr | virtual_state_udr;

    byte_stream_if #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) stream_if ();

    jtag_dr_shifter shifter0 (
        .tck    (tck),
        .arst_n (arst_n),
        .ir_in  (vjtag_instr_e'(ir_in)),
        .cdr    (virtual_state_cdr),
        .sdr    (virtual_state_sdr),
        .udr    (dr_end),
        .tdi    (tdi),
        .tdo    (tdo),
        .fifo   (stream_if.producer)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .tck    (tck),
        .arst_n (arst_n),
        .buf_if (stream_if.buffer)
    );

    cmd_sink sink0 (
        .tck       (tck),
        .arst_n    (arst_n),
        .fifo      (stream_if.consumer),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

//--- jtag_bridge_properties.sv
`timescale 1ns/100ps
`default_nettype none

module jtag_bridge_properties #(
    parameter int FIFO_DEPTH = 8
) (
    input wire       tck,
    input wire       arst_n,
    input wire [2:0] ir_in,
    input wire       virtual_state_cdr,
    input wire       virtual_state_sdr,
    input wire       virtual_state_e1dr,
    input wire       virtual_state_udr,
    input wire       tdi,
    input wire       out_ready,
    input wire       tdo,
    input wire       out_valid,
    input wire [7:0] out_data,
    input wire [7:0] ctrl
);
    import jtag_bridge_pkg::*;

    localparam int CAP = FIFO_DEPTH + 2; // Memory, output register and the byte held by the sink

    logic [2:0] bit_cnt;
    logic [7:0] in_sr;
    logic [7:0] tdo_sr;
    logic [7:0] exp_q [32];
    logic [4:0] wr_idx;
    logic [4:0] rd_idx;
    int         exp_cnt;
    int         stall_cnt;
    logic [7:0] lb_last;
    logic [7:0] ctrl_exp;
    logic [7:0] ctrl_d;
    logic [7:0] stat_exp;
    logic       ovf_m;
    logic       info_first;
    logic       held_d;
    logic [7:0] out_data_d;
    int         fail_cnt = 0;

    logic       shift_en;
    logic       byte_done;
    logic [7:0] rx_byte;
    logic [7:0] tx_byte;
    logic       data_in;
    logic       xfer;
    logic [7:0] exp_head;

    assign shift_en  = virtual_state_sdr && !virtual_state_cdr;
    assign byte_done = shift_en && (bit_cnt == 3'd7);
    assign rx_byte   = {tdi, in_sr[7:1]}; // Bits arrive LSB first
    assign tx_byte   = {tdo, tdo_sr[7:1]};
    assign data_in   = byte_done && (ir_in == DATA) && (exp_cnt < CAP);
    assign xfer      = out_valid && out_ready;
    assign exp_head  = exp_q[rd_idx];

    always_ff @(posedge tck or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt    <= '0;
            wr_idx     <= '0;
            rd_idx     <= '0;
            exp_cnt    <= 0;
            stall_cnt  <= 0;
            lb_last    <= '0;
            ctrl_exp   <= '0;
            ctrl_d     <= '0;
            stat_exp   <= '0;
            ovf_m      <= 1'b0;
            info_first <= 1'b1;
            held_d     <= 1'b0;
        end
        else
        begin
            if (virtual_state_cdr || virtual_state_e1dr || virtual_state_udr)
            begin
                bit_cnt <= '0;
            end
            else if (virtual_state_sdr)
            begin
                bit_cnt <= bit_cnt + 3'd1;
            end
            if (virtual_state_cdr)
            begin
                info_first <= 1'b1;
            end
            if (byte_done && (ir_in == DATA) && !data_in)
            begin
                ovf_m <= 1'b1; // No room left anywhere in the path
            end
            if (byte_done && (ir_in == LOOPBACK))
            begin
                lb_last <= rx_byte;
            end
            if (byte_done && (ir_in == CONTROL))
            begin
                ctrl_exp <= rx_byte;
            end
            if (byte_done && (ir_in == INFO))
            begin
                stat_exp   <= {ovf_m, 7'(exp_cnt - int'(out_valid))};
                info_first <= 1'b0;
            end
            if (data_in)
            begin
                wr_idx <= wr_idx + 5'd1;
            end
            if (xfer)
            begin
                rd_idx <= rd_idx + 5'd1;
            end
            exp_cnt <= exp_cnt + int'(data_in) - int'(xfer);
            if ((exp_cnt != 0) && out_ready && !out_valid)
            begin
                stall_cnt <= stall_cnt + 1; // Pending bytes while the stream would accept them
            end
            else
            begin
                stall_cnt <= 0;
            end
            ctrl_d  <= ctrl;
            held_d  <= out_valid && !out_ready;
        end
    end

    always_ff @(posedge tck)
    begin
        if (shift_en)
        begin
            in_sr  <= rx_byte;
            tdo_sr <= tx_byte;
        end
        if (data_in)
        begin
            exp_q[wr_idx] <= rx_byte;
        end
        out_data_d <= out_data;
    end

    a_stream_order: assert property (@(posedge tck) disable iff (!arst_n)
        xfer |-> (exp_cnt != 0) && (out_data == exp_head))
    else
    begin
        fail_cnt++;
        $error("FAIL %0t out_data expected %h got %h (pending %0d)",
               $time, $sampled(exp_head), $sampled(out_data), $sampled(exp_cnt));
    end

    // Every accepted DATA byte has to leave once out_ready stays high
    a_stream_live: assert property (@(posedge tck) disable iff (!arst_n)
        stall_cnt < 12)
    else
    begin
        fail_cnt++;
        $error("Pending DATA bytes never reached out_data at %0t", $time);
    end

    a_stream_hold: assert property (@(posedge tck) disable iff (!arst_n)
        held_d |-> out_valid && (out_data == out_data_d))
    else
    begin
        fail_cnt++;
        $error("FAIL %0t held out_valid expected 1 got %b, out_data expected %h got %h",
               $time, $sampled(out_valid), $sampled(out_data_d), $sampled(out_data));
    end

    a_loopback: assert property (@(posedge tck) disable iff (!arst_n)
        byte_done && (ir_in == LOOPBACK) |-> tx_byte == lb_last)
    else
    begin
        fail_cnt++;
        $error("FAIL %0t tdo loopback byte expected %h got %h",
               $time, $sampled(lb_last), $sampled(tx_byte));
    end

    a_info_id: assert property (@(posedge tck) disable iff (!arst_n)
        byte_done && (ir_in == INFO) && info_first |-> tx_byte == INFO_ID)
    else
    begin
        fail_cnt++;
        $error("FAIL %0t tdo identity byte expected %h got %h",
               $time, INFO_ID, $sampled(tx_byte));
    end

    a_info_status: assert property (@(posedge tck) disable iff (!arst_n)
        byte_done && (ir_in == INFO) && !info_first |-> tx_byte == stat_exp)
    else
    begin
        fail_cnt++;
        $error("FAIL %0t tdo status byte expected %h got %h",
               $time, $sampled(stat_exp), $sampled(tx_byte));
    end

    // Only a CONTROL byte may move ctrl, and it must land there
    a_ctrl_source: assert property (@(posedge tck) disable iff (!arst_n)
        (ctrl != ctrl_d) |-> ctrl == ctrl_exp)
    else
    begin
        fail_cnt++;
        $error("FAIL %0t ctrl expected %h got %h",
               $time, $sampled(ctrl_exp), $sampled(ctrl));
    end

    a_ctrl_update: assert property (@(posedge tck) disable iff (!arst_n)
        byte_done && (ir_in == CONTROL) |-> ##[1:64] ctrl == ctrl_exp)
    else
    begin
        fail_cnt++;
        $error("CONTROL byte never reached ctrl at %0t", $time);
    end

endmodule

bind jtag_bridge_top jtag_bridge_properties #(
    .FIFO_DEPTH (FIFO_DEPTH)
) props0 (
    .tck                (tck),
    .arst_n             (arst_n),
    .ir_in              (ir_in),
    .virtual_state_cdr  (virtual_state_cdr),
    .virtual_state_sdr  (virtual_state_sdr),
    .virtual_state_e1dr (virtual_state_e1dr),
    .virtual_state_udr  (virtual_state_udr),
    .tdi                (tdi),
    .out_ready          (out_ready),
    .tdo                (tdo),
    .out_valid          (out_valid),
    .out_data           (out_data),
    .ctrl               (ctrl)
);

`default_nettype wire

//--- tb_jtag_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_jtag_bridge;
    import jtag_bridge_pkg::*;

    localparam int FIFO_DEPTH   = 8;
    localparam int N_RAND       = 24;
    localparam int SCAN_BYTES   = 2 + 4 + 3 + 2 * N_RAND + 5 + (FIFO_DEPTH + 6) + 2;
    localparam int LIMIT_CYCLES = SCAN_BYTES * 20 + 2000;
    localparam int READY_LOW    = 0;
    localparam int READY_HIGH   = 1;
    localparam int READY_RANDOM = 2;

    logic         tck;
    logic         arst_n;
    logic [2:0]   ir_in;
    logic         cdr;
    logic         sdr;
    logic         e1dr;
    logic         udr;
    logic         tdi;
    logic         out_ready;
    wire          tdo;
    wire          out_valid;
    wire  [7:0]   out_data;
    wire  [7:0]   ctrl;
    int           ready_mode;
    vjtag_instr_e rand_modes [4];

    jtag_bridge_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .tck                (tck),
        .arst_n             (arst_n),
        .ir_in              (ir_in),
        .virtual_state_cdr  (cdr),
        .virtual_state_sdr  (sdr),
        .virtual_state_e1dr (e1dr),
        .virtual_state_udr  (udr),
        .tdi                (tdi),
        .out_ready          (out_ready),
        .tdo                (tdo),
        .out_valid          (out_valid),
        .out_data           (out_data),
        .ctrl               (ctrl)
    );

    initial
    begin
        tck = 1'b0;
        forever #50 tck = ~tck;
    end

    // Back-pressure source for the output stream
    initial
    begin
        out_ready = 1'b0;
        forever
        begin
            @(posedge tck);
            #20;
            case (ready_mode)
                READY_LOW:  out_ready = 1'b0;
                READY_HIGH: out_ready = 1'b1;
                default:    out_ready = 1'($urandom % 2);
            endcase
        end
    end

    task automatic step();
        @(posedge tck);
        #10;
    endtask

    // One DR scan as the virtual node sequences it: Capture, Shift, Exit1, Update
    task automatic scan_bytes(input vjtag_instr_e mode, input int n);
        logic [7:0] payload;
        ir_in = mode;
        cdr   = 1'b1;
        step();
        cdr = 1'b0;
        sdr = 1'b1;
        for (int i = 0; i < n; i++)
        begin
            payload = 8'($urandom);
            for (int b = 0; b < 8; b++)
            begin
                tdi = payload[b];
                step();
            end
        end
        sdr  = 1'b0;
        e1dr = 1'b1;
        step();
        e1dr = 1'b0;
        udr  = 1'b1;
        step();
        udr = 1'b0;
        step();
    endtask

    task automatic drain_stream();
        int idle;
        idle       = 0;
        ready_mode = READY_HIGH;
        while (idle < 16)
        begin
            step();
            idle = out_valid ? 0 : idle + 1;
        end
    endtask

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge tck);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired after %0d cycles", LIMIT_CYCLES);
    end

    initial
    begin
        wait (dut0.props0.fail_cnt != 0);
        $display("Simulation failed");
        $fatal(1, "A property check failed");
    end

    initial
    begin
        void'($urandom(80));
        rand_modes = '{DATA, LOOPBACK, DEBUG, MGMT};
        arst_n     = 1'b0;
        ir_in      = DATA;
        cdr        = 1'b0;
        sdr        = 1'b0;
        e1dr       = 1'b0;
        udr        = 1'b0;
        tdi        = 1'b0;
        ready_mode = READY_HIGH;
        repeat (5) @(posedge tck);
        #10;
        arst_n = 1'b1;
        step();

        scan_bytes(INFO, 2);
        scan_bytes(LOOPBACK, 4); // First echo is the reset value
        scan_bytes(CONTROL, 1);
        drain_stream();
        scan_bytes(DEBUG, 1);
        scan_bytes(MGMT, 1);
        drain_stream();

        ready_mode = READY_RANDOM;
        repeat (N_RAND) scan_bytes(rand_modes[$urandom % 4], 2);
        drain_stream();

        // Status read while bytes wait in the FIFO
        ready_mode = READY_LOW;
        scan_bytes(DATA, 3);
        scan_bytes(INFO, 2);
        drain_stream();

        ready_mode = READY_LOW;
        scan_bytes(DATA, FIFO_DEPTH + 4);
        scan_bytes(INFO, 2);
        drain_stream();
        scan_bytes(LOOPBACK, 2);
        drain_stream();

        if (dut0.props0.fail_cnt == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Simulation failed");
            $fatal(1, "Property checks reported failures");
        end
    end

endmodule

`default_nettype wire

//--- sim.f
jtag_bridge_pkg.sv
byte_stream_if.sv
jtag_dr_shifter.sv
byte_fifo.sv
cmd_sink.sv
jtag_bridge_top.sv
jtag_bridge_properties.sv
tb_jtag_bridge.sv
